/* verilog/jsp_dims_pkg.sv */
package jsp_dims_pkg;

  ////////////////////////////////////////
  // Serial port data widths
  ////////////////////////////////////////

  // Byte moving between the data register and the FIFO
  typedef logic [7:0] jsp_byte_t;

  // Credit or byte count as reported by the FIFO
  typedef logic [3:0] jsp_count_t;  // Free space, bytes available, user count

  // Bit position inside the byte being shifted
  typedef logic [2:0] jsp_bit_idx_t;

  ////////////////////////////////////////
  // Bit positions
  ////////////////////////////////////////

  // Index of the last bit, byte complete on this shift
  localparam jsp_bit_idx_t byte_last_bit = 3'd7;

endpackage

/* verilog/jsp_ctrl_pkg.sv */
package jsp_ctrl_pkg;

  // Write path sequencer, PC towards FIFO
  typedef enum logic [1:0] {
    wr_idle   = 2'b00,  // No session open
    wr_counts = 2'b01,  // Receiving user count byte
    wr_xfer   = 2'b10   // Receiving data bytes
  } wr_state_t;

  // Read path sequencer, FIFO towards PC
  typedef enum logic [1:0] {
    rd_idle   = 2'b00,  // No session open
    rd_counts = 2'b01,  // Sending status byte
    rd_rdack  = 2'b10,  // First bit of data byte, ack to FIFO
    rd_xfer   = 2'b11   // Remaining bits of data byte
  } rd_state_t;

endpackage

/* verilog/jsp_credit_counter.sv */
module jsp_credit_counter (
  input  logic                    tck_i,
  input  logic                    rst_i,
  input  logic                    load_i,        // Take a fresh credit value
  input  jsp_dims_pkg::jsp_count_t load_value_i,
  input  logic                    dec_i,         // Spend one credit
  output logic                    zero_o         // No credit left
);

  import jsp_dims_pkg::*;

  jsp_count_t count_q;  // Remaining credits

  // Load has priority, a fresh session overrides any spend
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= load_value_i;
    end else if (dec_i) begin
      count_q <= count_q - jsp_count_t'(1);
    end
  end

  // Combinational, seen by the sequencer in the same cycle
  assign zero_o = (count_q == '0);

endmodule

/* verilog/jsp_wr_fsm.sv */
module jsp_wr_fsm #(
  parameter int dbg_datareg_len = 64
) (
  input  logic                       tck_i,
  input  logic                       rst_i,
  input  logic                       tdi_i,
  // TAP controls
  input  logic                       module_select_i,
  input  logic                       capture_dr_i,
  input  logic                       shift_dr_i,
  input  logic                       update_dr_i,
  input  logic [dbg_datareg_len-1:0] data_register_i,  // Shared DR, shifts right
  // Credit counters
  input  logic                       space_zero_i,
  input  logic                       user_zero_i,
  output logic                       space_load_o,
  output logic                       user_load_o,
  output jsp_dims_pkg::jsp_count_t   user_count_o,
  // FIFO write side
  output jsp_dims_pkg::jsp_byte_t    biu_di_o,
  output logic                       biu_wr_strobe_o
);

  import jsp_dims_pkg::*;
  import jsp_ctrl_pkg::*;

  wr_state_t    state_q, state_d;
  jsp_bit_idx_t bit_cnt_q;      // Bits received of current byte
  logic         bit_clr;
  logic         bit_inc;
  logic         byte_end;       // Shift of this cycle completes a byte
  logic         session_start;

  assign session_start = module_select_i & capture_dr_i;
  assign byte_end      = (bit_cnt_q == byte_last_bit);

  // Incoming byte, bit 7 still on TDI, bits 6..0 already in the top of the DR
  assign biu_di_o     = {tdi_i, data_register_i[dbg_datareg_len-1 -: 7]};
  assign user_count_o = biu_di_o[7:4];  // High nibble of count byte

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= wr_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (bit_clr) begin
      bit_cnt_q <= '0;
    end else if (bit_inc) begin
      bit_cnt_q <= bit_cnt_q + jsp_bit_idx_t'(1);
    end
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      wr_idle: begin
        if (session_start) begin
          state_d = wr_counts;
        end
      end
      wr_counts: begin
        if (update_dr_i) begin
          state_d = wr_idle;
        end else if (shift_dr_i && byte_end) begin
          state_d = wr_xfer;  // Count byte done
        end
      end
      wr_xfer: begin
        if (update_dr_i) begin
          state_d = wr_idle;  // Session ends, stay here until then
        end
      end
      default: state_d = wr_idle;
    endcase
  end

  ////////////////////////////////////////
  // Mealy outputs
  ////////////////////////////////////////

  always_comb begin
    bit_clr         = 1'b0;
    bit_inc         = 1'b0;
    space_load_o    = 1'b0;
    user_load_o     = 1'b0;
    biu_wr_strobe_o = 1'b0;
    case (state_q)
      wr_idle: begin
        if (session_start) begin
          bit_clr      = 1'b1;
          space_load_o = 1'b1;  // Capture free space credits
        end
      end
      wr_counts: begin
        if (shift_dr_i) begin  // Pause and exit states leave everything
          bit_inc = 1'b1;
          if (byte_end) begin
            bit_clr     = 1'b1;
            user_load_o = 1'b1;
          end
        end
      end
      wr_xfer: begin
        if (shift_dr_i) begin
          bit_inc = 1'b1;
          if (byte_end) begin
            bit_clr = 1'b1;
            // Bytes beyond either credit are dropped
            biu_wr_strobe_o = ~(space_zero_i | user_zero_i);
          end
        end
      end
      default: begin
        bit_clr = 1'b1;
      end
    endcase
  end

endmodule

/* verilog/jsp_rd_fsm.sv */
module jsp_rd_fsm (
  input  logic tck_i,
  input  logic rst_i,
  // TAP controls
  input  logic module_select_i,
  input  logic capture_dr_i,
  input  logic shift_dr_i,
  input  logic update_dr_i,
  // Bytes available credit
  input  logic bytes_zero_i,
  output logic bytes_load_o,
  output logic bytes_dec_o,
  // Output shifter control
  output logic out_load_o,
  output logic out_shift_o,
  output logic status_sel_o,    // Load status byte instead of FIFO data
  // FIFO read side
  output logic biu_rd_strobe_o  // Ack of the byte on biu_do
);

  import jsp_dims_pkg::*;
  import jsp_ctrl_pkg::*;

  rd_state_t    state_q, state_d;
  jsp_bit_idx_t bit_cnt_q;      // Bits sent of current byte
  logic         bit_clr;
  logic         bit_inc;
  logic         byte_end;
  logic         session_start;

  assign session_start = module_select_i & capture_dr_i;
  assign byte_end      = (bit_cnt_q == byte_last_bit);

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= rd_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (bit_clr) begin
      bit_cnt_q <= '0;
    end else if (bit_inc) begin
      bit_cnt_q <= bit_cnt_q + jsp_bit_idx_t'(1);
    end
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  // All moves past idle wait for a shift cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      rd_idle: begin
        if (session_start) begin
          state_d = rd_counts;
        end
      end
      rd_counts, rd_xfer: begin
        if (update_dr_i) begin
          state_d = rd_idle;
        end else if (shift_dr_i && byte_end) begin
          state_d = rd_rdack;  // Next byte starts with its ack
        end
      end
      rd_rdack: begin
        if (update_dr_i) begin
          state_d = rd_idle;
        end else if (shift_dr_i) begin
          state_d = rd_xfer;
        end
      end
      default: state_d = rd_idle;
    endcase
  end

  ////////////////////////////////////////
  // Mealy outputs
  ////////////////////////////////////////

  always_comb begin
    bit_clr         = 1'b0;
    bit_inc         = 1'b0;
    bytes_load_o    = 1'b0;
    bytes_dec_o     = 1'b0;
    out_load_o      = 1'b0;
    out_shift_o     = 1'b0;
    status_sel_o    = 1'b0;
    biu_rd_strobe_o = 1'b0;
    case (state_q)
      rd_idle: begin
        if (session_start) begin
          bit_clr      = 1'b1;
          bytes_load_o = 1'b1;  // Capture bytes available
          out_load_o   = 1'b1;
          status_sel_o = 1'b1;  // Status byte goes out first
        end
      end
      rd_counts: begin
        if (shift_dr_i) begin
          bit_inc     = 1'b1;
          out_shift_o = 1'b1;
          if (byte_end) begin
            bit_clr = 1'b1;
            // First data byte latched here, ack comes in rd_rdack
            if (!bytes_zero_i) begin
              out_load_o  = 1'b1;
              out_shift_o = 1'b0;
            end
          end
        end
      end
      rd_rdack: begin
        if (shift_dr_i) begin
          bit_inc         = 1'b1;
          out_shift_o     = 1'b1;
          biu_rd_strobe_o = ~bytes_zero_i;  // Byte end never falls here
        end
      end
      rd_xfer: begin
        if (shift_dr_i) begin
          bit_inc     = 1'b1;
          out_shift_o = 1'b1;
          if (byte_end) begin
            bit_clr = 1'b1;
            if (!bytes_zero_i) begin
              out_load_o  = 1'b1;   // Next FIFO byte
              out_shift_o = 1'b0;
              bytes_dec_o = 1'b1;   // One data byte spent
            end
          end
        end
      end
      default: begin
        bit_clr = 1'b1;
      end
    endcase
  end

endmodule

/* verilog/jsp_tx_shifter.sv */
module jsp_tx_shifter (
  input  logic                     tck_i,
  input  logic                     rst_i,
  input  logic                     load_i,
  input  logic                     shift_i,
  input  logic                     status_sel_i,       // 1 = status byte, 0 = FIFO data
  input  jsp_dims_pkg::jsp_byte_t  biu_do_i,
  input  jsp_dims_pkg::jsp_count_t bytes_available_i,
  input  jsp_dims_pkg::jsp_count_t space_available_i,
  output logic                     tdo_o
);

  import jsp_dims_pkg::*;

  jsp_byte_t shift_q;    // Byte being sent, lsb first
  jsp_byte_t load_byte;

  // Status byte, bytes available high, free space low
  assign load_byte = status_sel_i ? {bytes_available_i, space_available_i} : biu_do_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      shift_q <= '0;
    end else if (load_i) begin
      shift_q <= load_byte;
    end else if (shift_i) begin
      shift_q <= {1'b0, shift_q[$bits(jsp_byte_t)-1:1]};  // Zero fill from the top
    end
  end

  assign tdo_o = shift_q[0];

endmodule

/* verilog/jsp_core.sv */
module jsp_core #(
  parameter int dbg_datareg_len = 64
) (
  input  logic                       tck_i,
  input  logic                       rst_i,
  // JTAG
  input  logic                       tdi_i,
  output logic                       module_tdo_o,
  // TAP states
  input  logic                       capture_dr_i,
  input  logic                       shift_dr_i,
  input  logic                       update_dr_i,
  input  logic                       module_select_i,
  input  logic [dbg_datareg_len-1:0] data_register_i,  // Shared with the other debug modules
  // FIFO side
  input  jsp_dims_pkg::jsp_byte_t    biu_do_i,
  input  jsp_dims_pkg::jsp_count_t   biu_space_available_i,
  input  jsp_dims_pkg::jsp_count_t   biu_bytes_available_i,
  output jsp_dims_pkg::jsp_byte_t    biu_di_o,
  output logic                       biu_wr_strobe_o,   // FIFO latches biu_di_o
  output logic                       biu_rd_strobe_o    // FIFO advances past biu_do_i
);

  import jsp_dims_pkg::*;

  // Write path
  logic       space_load;
  logic       space_zero;
  logic       user_load;
  logic       user_zero;
  jsp_count_t user_count;

  // Read path
  logic       bytes_load;
  logic       bytes_dec;
  logic       bytes_zero;
  logic       out_load;
  logic       out_shift;
  logic       status_sel;

  ////////////////////////////////////////
  // PC to FIFO
  ////////////////////////////////////////

  jsp_wr_fsm #(
    .dbg_datareg_len (dbg_datareg_len)
  ) u_wr_fsm (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .module_select_i (module_select_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .data_register_i (data_register_i),
    .space_zero_i    (space_zero),
    .user_zero_i     (user_zero),
    .space_load_o    (space_load),
    .user_load_o     (user_load),
    .user_count_o    (user_count),
    .biu_di_o        (biu_di_o),
    .biu_wr_strobe_o (biu_wr_strobe_o)
  );

  // Each write strobe spends one credit from both counts
  jsp_credit_counter u_space_cnt (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .load_i       (space_load),
    .load_value_i (biu_space_available_i),
    .dec_i        (biu_wr_strobe_o),
    .zero_o       (space_zero)
  );

  jsp_credit_counter u_user_cnt (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .load_i       (user_load),
    .load_value_i (user_count),
    .dec_i        (biu_wr_strobe_o),
    .zero_o       (user_zero)
  );

  ////////////////////////////////////////
  // FIFO to PC
  ////////////////////////////////////////

  jsp_rd_fsm u_rd_fsm (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .module_select_i (module_select_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .bytes_zero_i    (bytes_zero),
    .bytes_load_o    (bytes_load),
    .bytes_dec_o     (bytes_dec),
    .out_load_o      (out_load),
    .out_shift_o     (out_shift),
    .status_sel_o    (status_sel),
    .biu_rd_strobe_o (biu_rd_strobe_o)
  );

  jsp_credit_counter u_bytes_cnt (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .load_i       (bytes_load),
    .load_value_i (biu_bytes_available_i),
    .dec_i        (bytes_dec),
    .zero_o       (bytes_zero)
  );

  jsp_tx_shifter u_tx_shifter (
    .tck_i             (tck_i),
    .rst_i             (rst_i),
    .load_i            (out_load),
    .shift_i           (out_shift),
    .status_sel_i      (status_sel),
    .biu_do_i          (biu_do_i),
    .bytes_available_i (biu_bytes_available_i),
    .space_available_i (biu_space_available_i),
    .tdo_o             (module_tdo_o)
  );

endmodule

/* bench/jsp_model.svh */
////////////////////////////////////////
// FIFO and data register model
////////////////////////////////////////

logic [dr_len-1:0] dr_q;       // Shared DR with tdi entering at the msb
jsp_byte_t         rx_fifo[$]; // Bytes waiting for the host
jsp_byte_t         wr_log[$];  // Bytes the FIFO latched on write strobes
jsp_count_t        space_q;    // Free space reported by the FIFO
jsp_count_t        user_q;     // User count the host sends this session
int                rd_acks;    // Read strobes seen so far

// Counts and data as seen at capture
jsp_count_t        cap_space;
jsp_count_t        cap_avail;
jsp_byte_t         cap_rx[$];

// Effects of the last rising edge that apply at the next falling edge
logic              pend_shift;
logic              pend_tdi;
logic              pend_pop;
logic              pend_write;

task automatic model_init();
  dr_q       = '0;
  space_q    = '0;
  user_q     = '0;
  rd_acks    = 0;
  cap_space  = '0;
  cap_avail  = '0;
  pend_shift = 1'b0;
  pend_tdi   = 1'b0;
  pend_pop   = 1'b0;
  pend_write = 1'b0;
endtask

// Bytes available saturates at the nibble range
function automatic jsp_count_t fifo_avail();
  if (rx_fifo.size() > 15) return 4'd15;
  return jsp_count_t'(rx_fifo.size());
endfunction

task automatic apply_edge();
  if (pend_shift) dr_q = {pend_tdi, dr_q[dr_len-1:1]};  // Shift right
  if (pend_pop && rx_fifo.size() > 0) rx_fifo.delete(0);  // FIFO advances on ack
  if (pend_write && space_q != 0) space_q = space_q - 4'd1;
  pend_shift            = 1'b0;
  pend_pop              = 1'b0;
  pend_write            = 1'b0;
  data_register_i       = dr_q;
  biu_do_i              = (rx_fifo.size() > 0) ? rx_fifo[0] : 8'h00;
  biu_bytes_available_i = fifo_avail();
  biu_space_available_i = space_q;
endtask

task automatic model_capture();
  int i;
  cap_space = space_q;
  cap_avail = fifo_avail();
  cap_rx.delete();
  for (i = 0; i < cap_avail; i++) cap_rx.push_back(rx_fifo[i]);
endtask

// TDO is checked over the status byte and the N captured bytes only
function automatic logic tdo_checked(input int k);
  return (k >= 0) && (k < 8 || (k - 8) / 8 < cap_avail);
endfunction

function automatic logic expected_tdo(input int k);
  jsp_byte_t status;
  jsp_byte_t data;
  status = {cap_avail, cap_space};  // Space low nibble goes first
  if (k < 8) return status[k];
  data = cap_rx[(k - 8) / 8];
  return data[(k - 8) % 8];
endfunction

// Ack one shift cycle after each data byte load
function automatic logic rd_ack_expected(input int k);
  return (k >= 8) && (k % 8 == 0) && (k / 8 - 1 < cap_avail);
endfunction

// Strobe on the last bit of data byte j while j < min(U, S)
function automatic logic wr_expected(input int k);
  int credit;
  credit = (user_q < cap_space) ? user_q : cap_space;
  return (k >= 15) && (k % 8 == 7) && (k / 8 - 1 < credit);
endfunction

/* bench/jsp_tb.sv */
module jsp_tb;

  import jsp_dims_pkg::*;

  localparam int dr_len             = 64;
  localparam int clk_period         = 20;
  localparam int reset_cycles       = 5;
  localparam int num_sessions       = 60;
  localparam int max_shift          = 144;                // Count byte plus 17 data bytes
  localparam int max_session_cycles = 2 * max_shift + 4;  // Each shift may carry a pause
  localparam int watchdog_time      =
    (num_sessions * max_session_cycles + reset_cycles + 10) * clk_period;

  logic              tck_i;
  logic              rst_i;
  logic              tdi_i;
  logic              capture_dr_i;
  logic              shift_dr_i;
  logic              update_dr_i;
  logic              module_select_i;
  logic [dr_len-1:0] data_register_i;
  jsp_byte_t         biu_do_i;
  jsp_count_t        biu_space_available_i;
  jsp_count_t        biu_bytes_available_i;
  logic              module_tdo_o;
  jsp_byte_t         biu_di_o;
  logic              biu_wr_strobe_o;
  logic              biu_rd_strobe_o;

  logic [31:0] lfsr_q;      // Stimulus LFSR state
  int          err_cnt[5];  // Reset, status, write, read, pause

  `include "jsp_model.svh"

  jsp_core #(
    .dbg_datareg_len (dr_len)
  ) i_dut (
    .tck_i                 (tck_i),
    .rst_i                 (rst_i),
    .tdi_i                 (tdi_i),
    .module_tdo_o          (module_tdo_o),
    .capture_dr_i          (capture_dr_i),
    .shift_dr_i            (shift_dr_i),
    .update_dr_i           (update_dr_i),
    .module_select_i       (module_select_i),
    .data_register_i       (data_register_i),
    .biu_do_i              (biu_do_i),
    .biu_space_available_i (biu_space_available_i),
    .biu_bytes_available_i (biu_bytes_available_i),
    .biu_di_o              (biu_di_o),
    .biu_wr_strobe_o       (biu_wr_strobe_o),
    .biu_rd_strobe_o       (biu_rd_strobe_o)
  );

  initial begin
    tck_i = 1'b0;
    forever #(clk_period / 2) tck_i = ~tck_i;
  end

  initial begin  // Watchdog
    #(watchdog_time);
    $display("Timeout: sessions did not finish within %0d time units", watchdog_time);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Random source and reporting
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};  // One step per bit
    end
  endtask

  task automatic report_value(input string name, input int cat, input int sn, input int k,
                              input logic [31:0] exp, input logic [31:0] act);
    err_cnt[cat]++;
    $display("[ERROR] %s: session %0d, bit %0d, expected %0h, actual %0h",
             name, sn, k, exp, act);
  endtask

  // k < 0 marks a cycle without shift_dr
  task automatic sample_cycle(input int sn, input int k, input jsp_byte_t exp_byte);
    logic exp_rd;
    logic exp_wr;
    #(clk_period / 4);  // Mealy outputs settled before the edge
    exp_rd = rd_ack_expected(k);
    exp_wr = wr_expected(k);
    if (tdo_checked(k) && module_tdo_o !== expected_tdo(k)) begin
      if (k < 8) report_value("status byte", 1, sn, k, expected_tdo(k), module_tdo_o);
      else report_value("read data", 3, sn, k, expected_tdo(k), module_tdo_o);
    end
    if (biu_rd_strobe_o !== exp_rd) begin
      report_value("read ack", (k < 0) ? 4 : 3, sn, k, exp_rd, biu_rd_strobe_o);
    end
    if (biu_wr_strobe_o !== exp_wr) begin
      report_value("write strobe", (k < 0) ? 4 : 2, sn, k, exp_wr, biu_wr_strobe_o);
    end
    if (biu_wr_strobe_o === 1'b1) begin
      if (biu_di_o !== exp_byte) report_value("write data", 2, sn, k, exp_byte, biu_di_o);
      wr_log.push_back(biu_di_o);
    end
    if (biu_rd_strobe_o === 1'b1) rd_acks++;
    pend_shift = shift_dr_i;
    pend_tdi   = tdi_i;
    pend_pop   = (biu_rd_strobe_o === 1'b1);
    pend_write = (biu_wr_strobe_o === 1'b1);
  endtask

  ////////////////////////////////////////
  // DR session
  ////////////////////////////////////////

  task automatic run_session(input int sn);
    jsp_byte_t   host[$];  // Count byte, then data bytes
    jsp_byte_t   cur;
    logic [31:0] r;
    logic        pauses;
    int          i, n, k, len, n_full, wr_exp, rd_exp, wr_start, ack_start;
    draw_bits(3, r);  // Top up the FIFO towards the host
    n = r[2:0];
    for (i = 0; i < n; i++) begin
      draw_bits(8, r);
      if (rx_fifo.size() < 20) rx_fifo.push_back(r[7:0]);
    end
    draw_bits(4, r);
    space_q = r[3:0];
    draw_bits(8, r);
    len = r % (max_shift + 1);  // Often ends inside a byte
    for (i = 0; i <= len / 8; i++) begin
      draw_bits(8, r);
      host.push_back(r[7:0]);
    end
    cur    = host[0];
    user_q = cur[7:4];
    draw_bits(1, r);
    pauses    = r[0];
    wr_start  = wr_log.size();
    ack_start = rd_acks;
    @(negedge tck_i);
    apply_edge();
    module_select_i = 1'b1;
    capture_dr_i    = 1'b1;
    model_capture();  // Same counts the DUT captures on this edge
    sample_cycle(sn, -1, 8'h00);
    for (k = 0; k < len; k++) begin
      if (pauses) begin
        draw_bits(2, r);
        if (r[1:0] == 2'b11) begin  // Pause cycle
          @(negedge tck_i);
          apply_edge();
          capture_dr_i = 1'b0;
          shift_dr_i   = 1'b0;
          sample_cycle(sn, -1, 8'h00);
        end
      end
      @(negedge tck_i);
      apply_edge();
      cur          = host[k / 8];
      capture_dr_i = 1'b0;
      shift_dr_i   = 1'b1;
      tdi_i        = cur[k % 8];  // lsb first
      sample_cycle(sn, k, cur);
    end
    @(negedge tck_i);
    apply_edge();
    capture_dr_i = 1'b0;
    shift_dr_i   = 1'b0;
    update_dr_i  = 1'b1;
    sample_cycle(sn, -1, 8'h00);
    @(negedge tck_i);
    apply_edge();
    update_dr_i     = 1'b0;
    module_select_i = 1'b0;
    sample_cycle(sn, -1, 8'h00);
    // Whole-session credit totals
    n_full = (len >= 8) ? (len - 8) / 8 : 0;
    wr_exp = (user_q < cap_space) ? user_q : cap_space;
    if (n_full < wr_exp) wr_exp = n_full;
    rd_exp = (len > 8) ? (len - 1) / 8 : 0;
    if (rd_exp > cap_avail) rd_exp = cap_avail;
    if (wr_log.size() - wr_start != wr_exp) begin
      report_value("write count", 2, sn, len, wr_exp, wr_log.size() - wr_start);
    end
    if (rd_acks - ack_start != rd_exp) begin
      report_value("read ack count", 3, sn, len, rd_exp, rd_acks - ack_start);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int i;
    int sn;
    int total;
    lfsr_q                = 32'h170659d6;
    rst_i                 = 1'b1;
    tdi_i                 = 1'b0;
    capture_dr_i          = 1'b0;
    shift_dr_i            = 1'b0;
    update_dr_i           = 1'b0;
    module_select_i       = 1'b0;
    data_register_i       = '0;
    biu_do_i              = '0;
    biu_space_available_i = '0;
    biu_bytes_available_i = '0;
    model_init();
    // Final pass follows a rising edge out of reset
    for (i = 1; i <= reset_cycles + 1; i++) begin
      @(negedge tck_i);
      rst_i = (i < reset_cycles);
      #(clk_period / 4);
      if ({module_tdo_o, biu_wr_strobe_o, biu_rd_strobe_o} !== 3'b000) begin
        report_value("reset outputs", 0, -1, i, 3'b000,
                     {module_tdo_o, biu_wr_strobe_o, biu_rd_strobe_o});
      end
    end
    for (sn = 0; sn < num_sessions; sn++) run_session(sn);
    total = err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] + err_cnt[4];
    $display("Errors: reset %0d, status %0d, write %0d, read %0d, pause %0d, total %0d",
             err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], err_cnt[4], total);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
verilog/jsp_dims_pkg.sv
verilog/jsp_ctrl_pkg.sv
verilog/jsp_credit_counter.sv
verilog/jsp_wr_fsm.sv
verilog/jsp_rd_fsm.sv
verilog/jsp_tx_shifter.sv
verilog/jsp_core.sv
bench/jsp_tb.sv
